/* vramPkg.sv */
package vramPkg;

	// One VRAM word, both byte chips together
	localparam int vramDataW = 16;

	// Sprite tile number
	// 16 bits from the low word, 4 from the high word
	localparam int sprTileW = 20;

	// Fix tile number from the map entry
	localparam int fixTileW = 12;

	// Fixed four-slot cycle of CLK_6M
	// Order matters, the counter simply counts through it
	typedef enum logic [1:0]
	{
		slotCpu   = 2'd0,
		slotSprLo = 2'd1,
		slotSprHi = 2'd2,
		slotFix   = 2'd3
	} slotT;

	// CPU port handshake state
	// Idle waits for a request
	// Pending waits for the slot 0 access
	// Done holds the ack until the host lets go
	typedef enum logic [1:0]
	{
		cpuIdle    = 2'd0,
		cpuPending = 2'd1,
		cpuDone    = 2'd2
	} cpuStateT;

endpackage

/* slowVramIf.sv */
`timescale 1ns/1ps

interface slowVramIf #(
	parameter int addrWidth = 15
);

	// Request side, set up by the CPU port
	logic req;
	logic [addrWidth-1:0] addr;
	logic [vramPkg::vramDataW-1:0] wrData;
	logic write;

	// Result side, one-cycle pulse from the sequencer
	logic done;
	logic [vramPkg::vramDataW-1:0] rdData;

	// CPU port end
	modport port (output req, output addr, output wrData, output write,
		input done, input rdData);

	// Slot sequencer end
	modport slot (input req, input addr, input wrData, input write,
		output done, output rdData);

endinterface

/* cpuPort.sv */
`timescale 1ns/1ps

module cpuPort #(
	parameter int addrWidth = 15
)(
	input  logic CLK_6M,
	input  logic rstN,
	input  logic cpuReq,
	input  logic [addrWidth-1:0] cpuAddr,
	input  logic [vramPkg::vramDataW-1:0] cpuWrData,
	input  logic cpuWrite,
	output logic cpuAck,
	output logic [vramPkg::vramDataW-1:0] cpuRdData,
	slowVramIf.port bus
);

	vramPkg::cpuStateT state;

	// Held copy of the host request
	logic [addrWidth-1:0] addrQ;
	logic [vramPkg::vramDataW-1:0] dataQ;
	logic writeQ;

	// Four-phase handshake FSM
	always_ff @(posedge CLK_6M)
	begin
		if (!rstN)
			state <= vramPkg::cpuIdle;
		else
		begin
			case (state)
				vramPkg::cpuIdle:
					if (cpuReq)
						state <= vramPkg::cpuPending;
				// Wait for the sequencer to serve slot 0
				vramPkg::cpuPending:
					if (bus.done)
						state <= vramPkg::cpuDone;
				// Ack stays up while the host keeps req high
				vramPkg::cpuDone:
					if (!cpuReq)
						state <= vramPkg::cpuIdle;
				default:
					state <= vramPkg::cpuIdle;
			endcase
		end
	end

	// Latch address, data and direction on acceptance
	// Host is free to change them afterwards
	always_ff @(posedge CLK_6M)
	begin
		if (state == vramPkg::cpuIdle && cpuReq)
		begin
			addrQ <= cpuAddr;
			dataQ <= cpuWrData;
			writeQ <= cpuWrite;
		end
		// Read result, kept until the next access
		if (state == vramPkg::cpuPending && bus.done)
			cpuRdData <= bus.rdData;
	end

	// Ack drops one cycle after req falls
	assign cpuAck = (state == vramPkg::cpuDone);

	// Forward to sequencer only while waiting
	assign bus.req = (state == vramPkg::cpuPending);
	assign bus.addr = addrQ;
	assign bus.wrData = dataQ;
	assign bus.write = writeQ;

endmodule

/* slowVram.sv */
`timescale 1ns/1ps

module slowVram #(
	parameter int addrWidth = 15
)(
	input  logic CLK_6M,
	input  logic [addrWidth-1:0] addr,
	input  logic [vramPkg::vramDataW-1:0] wrData,
	input  logic wrEn,
	output logic [vramPkg::vramDataW-1:0] rdData
);

	// Upper and lower byte chips modelled as one word array
	localparam int depth = 2 ** addrWidth;

	logic [vramPkg::vramDataW-1:0] mem [0:depth-1];

	// Write lands at the edge ending the slot
	always_ff @(posedge CLK_6M)
	begin
		if (wrEn)
			mem[addr] <= wrData;
	end

	// Async read
	// Data is usable within the same slot
	assign rdData = mem[addr];

endmodule

/* slowCycle.sv */
`timescale 1ns/1ps

module slowCycle #(
	parameter int addrWidth = 15,
	parameter logic [3:0] fixMapBase = 4'd14
)(
	input  logic CLK_6M,
	input  logic rstN,
	input  logic hsync,
	input  logic [5:0] hCount,
	input  logic [4:0] vCount,
	input  logic [8:0] sprNb,
	input  logic [4:0] sprIdx,
	slowVramIf.slot bus,
	output logic [vramPkg::vramDataW-1:0] slotWord,
	output vramPkg::slotT slotKind,
	output logic slotStrobe
);

	vramPkg::slotT slot;

	logic [addrWidth-1:0] vramAddr;
	logic [addrWidth-1:0] fixAddr;
	logic [13:0] sprPair;
	logic [vramPkg::vramDataW-1:0] vramRd;
	logic cpuGo;
	logic wrEn;

	// Slot counter
	// Hsync parks it on the CPU slot so accesses still get through
	always_ff @(posedge CLK_6M)
	begin
		if (!rstN || hsync)
			slot <= vramPkg::slotCpu;
		else
			slot <= vramPkg::slotT'(slot + 2'd1);
	end

	// CPU slot in use
	// Masked during the done pulse so a repeated slot 0 is not a second access
	assign cpuGo = (slot == vramPkg::slotCpu) && bus.req && !bus.done;
	assign wrEn = cpuGo && bus.write;

	// Attribute pair base, two words per sprite entry
	assign sprPair = {sprNb, sprIdx};

	// Fix map entry for the current 8x8 cell
	assign fixAddr = addrWidth'({fixMapBase, hCount, vCount});

	// VRAM address per slot
	always_comb
	begin
		case (slot)
			vramPkg::slotCpu:
				vramAddr = bus.addr;
			vramPkg::slotSprLo:
				vramAddr = addrWidth'({sprPair, 1'b0});
			vramPkg::slotSprHi:
				vramAddr = addrWidth'({sprPair, 1'b1});
			default:
				vramAddr = fixAddr;
		endcase
	end

	slowVram #(
		.addrWidth(addrWidth)
	) u_vram (
		.CLK_6M(CLK_6M),
		.addr(vramAddr),
		.wrData(bus.wrData),
		.wrEn(wrEn),
		.rdData(vramRd)
	);

	// CPU result, one-cycle done pulse
	always_ff @(posedge CLK_6M)
	begin
		if (!rstN)
			bus.done <= 1'b0;
		else
			bus.done <= cpuGo;
	end

	// Read word sampled at the end of slot 0
	always_ff @(posedge CLK_6M)
	begin
		if (cpuGo)
			bus.rdData <= vramRd;
	end

	// Video slot capture
	// Strobe only for slots 1 to 3
	always_ff @(posedge CLK_6M)
	begin
		if (!rstN)
			slotStrobe <= 1'b0;
		else
			slotStrobe <= (slot != vramPkg::slotCpu);
	end

	// Word and kind qualified by the strobe
	always_ff @(posedge CLK_6M)
	begin
		slotWord <= vramRd;
		slotKind <= slot;
	end

endmodule

/* attrDecode.sv */
`timescale 1ns/1ps

module attrDecode (
	input  logic CLK_6M,
	input  logic rstN,
	input  logic [vramPkg::vramDataW-1:0] slotWord,
	input  vramPkg::slotT slotKind,
	input  logic slotStrobe,
	output logic [vramPkg::sprTileW-1:0] sprTileNb,
	output logic [7:0] sprPal,
	output logic [1:0] sprAa,
	output logic [1:0] sprFlip,
	output logic sprAttrValid,
	output logic [vramPkg::fixTileW-1:0] fixTileNb,
	output logic [3:0] fixPal,
	output logic fixAttrValid
);

	// Low word of the pair until the high word arrives
	logic [vramPkg::vramDataW-1:0] sprLo;

	always_ff @(posedge CLK_6M)
	begin
		if (slotStrobe && slotKind == vramPkg::slotSprLo)
			sprLo <= slotWord;
	end

	// Sprite fields from the high word
	always_ff @(posedge CLK_6M)
	begin
		if (!rstN)
		begin
			sprTileNb <= '0;
			sprPal <= '0;
			sprAa <= '0;
			sprFlip <= '0;
			sprAttrValid <= 1'b0;
		end
		else
		begin
			sprAttrValid <= slotStrobe && slotKind == vramPkg::slotSprHi;
			if (slotStrobe && slotKind == vramPkg::slotSprHi)
			begin
				// Upper tile nibble sits in bits 7:4
				sprTileNb <= {slotWord[7:4], sprLo};
				sprPal <= slotWord[15:8];
				sprAa <= slotWord[3:2];
				sprFlip <= slotWord[1:0];
			end
		end
	end

	// Fix map entry
	always_ff @(posedge CLK_6M)
	begin
		if (!rstN)
		begin
			fixTileNb <= '0;
			fixPal <= '0;
			fixAttrValid <= 1'b0;
		end
		else
		begin
			fixAttrValid <= slotStrobe && slotKind == vramPkg::slotFix;
			if (slotStrobe && slotKind == vramPkg::slotFix)
			begin
				fixPal <= slotWord[15:12];
				fixTileNb <= slotWord[11:0];
			end
		end
	end

endmodule

/* slowVramTop.sv */
`timescale 1ns/1ps

module slowVramTop #(
	parameter int addrWidth = 15,
	parameter logic [3:0] fixMapBase = 4'd14
)(
	input  logic CLK_6M,
	input  logic rstN,
	// Host side, four-phase handshake
	input  logic cpuReq,
	output logic cpuAck,
	input  logic [addrWidth-1:0] cpuAddr,
	input  logic [vramPkg::vramDataW-1:0] cpuWrData,
	input  logic cpuWrite,
	output logic [vramPkg::vramDataW-1:0] cpuRdData,
	// Scan position
	input  logic hsync,
	input  logic [5:0] hCount,
	input  logic [4:0] vCount,
	input  logic [8:0] sprNb,
	input  logic [4:0] sprIdx,
	// Decoded attributes
	output logic [vramPkg::sprTileW-1:0] sprTileNb,
	output logic [7:0] sprPal,
	output logic [1:0] sprAa,
	output logic [1:0] sprFlip,
	output logic sprAttrValid,
	output logic [vramPkg::fixTileW-1:0] fixTileNb,
	output logic [3:0] fixPal,
	output logic fixAttrValid
);

	// CPU access between port and sequencer
	slowVramIf #(.addrWidth(addrWidth)) cpuBus ();

	// Sequencer to decoder
	logic [vramPkg::vramDataW-1:0] slotWord;
	vramPkg::slotT slotKind;
	logic slotStrobe;

	cpuPort #(
		.addrWidth(addrWidth)
	) u_cpuPort (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.cpuReq(cpuReq),
		.cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData),
		.cpuWrite(cpuWrite),
		.cpuAck(cpuAck),
		.cpuRdData(cpuRdData),
		.bus(cpuBus.port)
	);

	slowCycle #(
		.addrWidth(addrWidth),
		.fixMapBase(fixMapBase)
	) u_slowCycle (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.hsync(hsync),
		.hCount(hCount),
		.vCount(vCount),
		.sprNb(sprNb),
		.sprIdx(sprIdx),
		.bus(cpuBus.slot),
		.slotWord(slotWord),
		.slotKind(slotKind),
		.slotStrobe(slotStrobe)
	);

	attrDecode u_attrDecode (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.slotWord(slotWord),
		.slotKind(slotKind),
		.slotStrobe(slotStrobe),
		.sprTileNb(sprTileNb),
		.sprPal(sprPal),
		.sprAa(sprAa),
		.sprFlip(sprFlip),
		.sprAttrValid(sprAttrValid),
		.fixTileNb(fixTileNb),
		.fixPal(fixPal),
		.fixAttrValid(fixAttrValid)
	);

endmodule

/* slowVram_assert.sv */
`timescale 1ns/1ps

module slowVramAssert (
	input logic CLK_6M,
	input logic rstN,
	input logic cpuReq,
	input logic cpuAck,
	input logic sprAttrValid,
	input logic fixAttrValid
);

	// Failures seen by the three rules
	int failCount = 0;

	// Ack only answers a live request
	ackNeedsReq: assert property (@(posedge CLK_6M) disable iff (!rstN)
		$rose(cpuAck) |-> cpuReq)
	else
	begin
		$error("cpuAck rose without cpuReq");
		failCount++;
	end

	// Sprite and fix strobes come from different slots
	oneStrobe: assert property (@(posedge CLK_6M) disable iff (!rstN)
		!(sprAttrValid && fixAttrValid))
	else
	begin
		$error("both valid strobes high");
		failCount++;
	end

	// Ack holds while the host keeps req up
	ackHolds: assert property (@(posedge CLK_6M) disable iff (!rstN)
		cpuAck && cpuReq |=> cpuAck)
	else
	begin
		$error("cpuAck dropped before cpuReq");
		failCount++;
	end

endmodule

bind slowVramTop slowVramAssert u_slowVramAssert (
	.CLK_6M(CLK_6M),
	.rstN(rstN),
	.cpuReq(cpuReq),
	.cpuAck(cpuAck),
	.sprAttrValid(sprAttrValid),
	.fixAttrValid(fixAttrValid)
);

/* tbSlowVram.sv */
`timescale 1ns/1ps

module tbSlowVram;

	logic CLK_6M = 1'b0;
	logic rstN;
	logic cpuReq, cpuWrite, hsync;
	logic [14:0] cpuAddr;
	logic [15:0] cpuWrData;
	logic [5:0] hCount;
	logic [4:0] vCount;
	logic [8:0] sprNb;
	logic [4:0] sprIdx;
	logic cpuAck, sprAttrValid, fixAttrValid;
	logic [15:0] cpuRdData;
	logic [19:0] sprTileNb;
	logic [7:0] sprPal;
	logic [1:0] sprAa, sprFlip;
	logic [11:0] fixTileNb;
	logic [3:0] fixPal;

	// One record per line, see the vector file for the column layout
	logic [127:0] vecs [0:63];
	logic [127:0] v;
	integer seed = 32'h835b_aa74;
	int errCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int errBefore;
	int pos;
	bit timedOut = 0;

	slowVramTop #(.addrWidth(15), .fixMapBase(4'd14)) u_slowVramTop (.*);

	always #4 CLK_6M = ~CLK_6M;

	function automatic logic probe(input int which);
		case (which)
			0: return cpuAck;
			1: return sprAttrValid;
			default: return fixAttrValid;
		endcase
	endfunction

	// Steps at least one edge, then polls until the level or a timeout
	task automatic waitLevel(input int which, input logic level, input string what);
		int n;
		if (timedOut)
			return;
		n = 0;
		@(posedge CLK_6M) #2;
		while (probe(which) !== level && n < 40)
		begin
			@(posedge CLK_6M) #2;
			n++;
		end
		if (probe(which) !== level)
		begin
			$display("Timeout after 40 cycles waiting for %s", what);
			timedOut = 1;
		end
	endtask

	task automatic check(input logic ok, input string msg);
		assert (ok)
		else
		begin
			$display("FAILED %0t: %s", $time, msg);
			errCount++;
		end
	endtask

	// Full four-phase exchange on the host port
	task automatic cpuAccess(input logic wr, input logic [14:0] a, input logic [15:0] d);
		@(posedge CLK_6M) #1;
		cpuAddr = a;
		cpuWrData = d;
		cpuWrite = wr;
		cpuReq = 1'b1;
		waitLevel(0, 1'b1, "cpuAck to rise");
		if (!wr && !timedOut)
			check(cpuRdData === d, $sformatf("read %h got %h want %h", a, cpuRdData, d));
		@(posedge CLK_6M) #1;
		cpuReq = 1'b0;
		waitLevel(0, 1'b0, "cpuAck to fall");
	endtask

	// Second strobe of each kind, the first may mix old scan inputs
	task automatic scanCheck();
		waitLevel(1, 1'b1, "sprAttrValid");
		waitLevel(1, 1'b1, "sprAttrValid again");
		if (!timedOut)
		begin
			check(sprTileNb === v[51:32], $sformatf("sprTileNb %h", sprTileNb));
			check(sprPal === v[31:24], $sformatf("sprPal %h", sprPal));
			check(sprAa === v[21:20], $sformatf("sprAa %h", sprAa));
			check(sprFlip === v[17:16], $sformatf("sprFlip %h", sprFlip));
		end
		waitLevel(2, 1'b1, "fixAttrValid");
		waitLevel(2, 1'b1, "fixAttrValid again");
		if (!timedOut)
		begin
			check(fixTileNb === v[15:4], $sformatf("fixTileNb %h", fixTileNb));
			check(fixPal === v[3:0], $sformatf("fixPal %h", fixPal));
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		{cpuReq, cpuWrite, hsync} = '0;
		cpuAddr = '0;
		cpuWrData = '0;
		{hCount, vCount, sprNb, sprIdx} = '0;
		for (int i = 0; i < 64; i++)
			vecs[i] = '0;
		$readmemh("slowVramVectors.txt", vecs);
		repeat (4) @(posedge CLK_6M);
		#1 rstN = 1'b1;
		@(posedge CLK_6M) #2;
		check(!cpuAck && !sprAttrValid && !fixAttrValid, "outputs not idle after reset");
		for (int i = 0; i < 64 && !timedOut && vecs[i][127:124] != 4'd0; i++)
		begin
			v = vecs[i];
			errBefore = errCount;
			testCount++;
			case (v[127:124])
				4'd1: cpuAccess(1'b1, v[118:104], v[103:88]);
				4'd2: cpuAccess(1'b0, v[118:104], v[103:88]);
				default:
				begin
					@(posedge CLK_6M) #1;
					sprNb = v[84:76];
					sprIdx = v[72:68];
					hCount = v[65:60];
					vCount = v[56:52];
					if (v[120])
					begin
						// Hsync at a random slot, with a read while it is high
						pos = $unsigned($random(seed)) % 4;
						repeat (pos) @(posedge CLK_6M);
						#1 hsync = 1'b1;
						cpuAccess(1'b0, v[118:104], v[103:88]);
						@(posedge CLK_6M) #1;
						hsync = 1'b0;
						// Restarted counter puts slot 2 data out on the fourth edge
						repeat (3) @(posedge CLK_6M);
						#1;
						if (!timedOut)
							check(sprAttrValid === 1'b0, "sprAttrValid before restart slot 2");
						@(posedge CLK_6M) #1;
						if (!timedOut)
							check(sprAttrValid === 1'b1, "sprAttrValid missing after hsync");
					end
					scanCheck();
				end
			endcase
			if (errCount != errBefore)
				failedTests++;
			$display("Test %0d kind %0d finished with %0d errors", i, v[127:124],
				errCount - errBefore);
		end
		$display("Tests %0d, failed %0d, errors %0d", testCount, failedTests, errCount);
		if (timedOut || errCount != 0 || u_slowVramTop.u_slowVramAssert.failCount != 0)
			$display("sim failed");
		else
			$display("sim passed");
		$finish;
	end

endmodule

/* slowVramVectors.txt */
// kind(1=W 2=R 3=S) hsync addr data sprNb sprIdx hCount vCount
// sprTile sprPal sprAa sprFlip fixTile fixPal
1_0_0486_BEEF_000_00_00_00_00000_00_0_0_000_0
1_0_0487_5A7D_000_00_00_00_00000_00_0_0_000_0
1_0_70A7_9123_000_00_00_00_00000_00_0_0_000_0
2_0_0486_BEEF_000_00_00_00_00000_00_0_0_000_0
2_0_0487_5A7D_000_00_00_00_00000_00_0_0_000_0
2_0_70A7_9123_000_00_00_00_00000_00_0_0_000_0
3_0_0000_0000_012_03_05_07_7BEEF_5A_3_1_123_9
// Writes beside the scanned addresses
1_0_0100_FFFF_000_00_00_00_00000_00_0_0_000_0
1_0_7000_0000_000_00_00_00_00000_00_0_0_000_0
1_0_0488_1234_000_00_00_00_00000_00_0_0_000_0
1_0_70A6_AAAA_000_00_00_00_00000_00_0_0_000_0
3_0_0000_0000_012_03_05_07_7BEEF_5A_3_1_123_9
// Second sprite and cell at the top of the ranges
1_0_7FFE_0001_000_00_00_00_00000_00_0_0_000_0
1_0_7FFF_C3F0_000_00_00_00_00000_00_0_0_000_0
1_0_77FF_0FFF_000_00_00_00_00000_00_0_0_000_0
2_0_7FFE_0001_000_00_00_00_00000_00_0_0_000_0
3_0_0000_0000_1FF_1F_3F_1F_F0001_C3_0_0_FFF_0
// Hsync pulses with a read during hsync
3_1_7FFF_C3F0_1FF_1F_3F_1F_F0001_C3_0_0_FFF_0
3_1_0486_BEEF_012_03_05_07_7BEEF_5A_3_1_123_9
2_0_0488_1234_000_00_00_00_00000_00_0_0_000_0
0_0_0000_0000_000_00_00_00_00000_00_0_0_000_0

/* filelist.f */
vramPkg.sv
slowVramIf.sv
cpuPort.sv
slowVram.sv
slowCycle.sv
attrDecode.sv
slowVramTop.sv
slowVram_assert.sv
tbSlowVram.sv

/* Bender.yml */
package:
  name: slow_vram

sources:
  - vramPkg.sv
  - slowVramIf.sv
  - cpuPort.sv
  - slowVram.sv
  - slowCycle.sv
  - attrDecode.sv
  - slowVramTop.sv
  - target: test
    files:
      - slowVram_assert.sv
      - tbSlowVram.sv
